/* rv_core.f */
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
tb_clock_gen.sv
tb_rv_core.sv

/* Makefile */
sim:
	verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* rv_core_patterns.hex */
// one rv32i instruction word per line, word address 0 first
// hex word, then its assembly
00001463 // 00 bne  x0, x0, +8 (not taken)
800000b7 // 04 lui  x1, 0x80000
fff08113 // 08 addi x2, x1, -1
fff00193 // 0c addi x3, x0, -1
12345217 // 10 auipc x4, 0x12345
0001a293 // 14 slti  x5, x3, 0
fff13313 // 18 sltiu x6, x2, -1
fff14393 // 1c xori  x7, x2, -1
0f00e413 // 20 ori   x8, x1, 0xf0
7ff1f493 // 24 andi  x9, x3, 0x7ff
00419513 // 28 slli  x10, x3, 4
01f0d593 // 2c srli  x11, x1, 31
4040d613 // 30 srai  x12, x1, 4
006106b3 // 34 add  x13, x2, x6
40608733 // 38 sub  x14, x1, x6
00a197b3 // 3c sll  x15, x3, x10
4030d833 // 40 sra  x16, x1, x3
00b3d8b3 // 44 srl  x17, x7, x11
0020a933 // 48 slt  x18, x1, x2
0020b9b3 // 4c sltu x19, x1, x2
0030ca33 // 50 xor  x20, x1, x3
00946ab3 // 54 or   x21, x8, x9
00c1fb33 // 58 and  x22, x3, x12
00518013 // 5c addi x0, x3, 5
00200bb3 // 60 add  x23, x0, x2
00300c13 // 64 addi x24, x0, 3
007c8c93 // 68 addi x25, x25, 7
fffc0c13 // 6c addi x24, x24, -1
fe0c1ce3 // 70 bne  x24, x0, -8
000c0463 // 74 beq  x24, x0, +8 (taken)
00100d13 // 78 addi x26, x0, 1 (skipped)
000c8463 // 7c beq  x25, x0, +8 (not taken)
02208033 // 80 mul  x0, x1, x2 (illegal)
00000073 // 84 ecall

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          period_ns     = 100;
  localparam int          reset_min     = 10;
  localparam int          imem_depth    = 64;
  localparam int          loop_bound    = 3;  // longest loop in the program
  localparam string       patterns_file = "rv_core_patterns.hex";
  localparam logic [31:0] rand_seed     = 32'hf2c2_e42a;

  logic                    clk;
  logic                    rst;
  logic [rv_pkg::xlen-1:0] insn;
  logic [rv_pkg::xlen-1:0] pc;
  logic                    wb_en;
  logic [4:0]              wb_addr;
  logic [rv_pkg::xlen-1:0] wb_data;
  logic                    halt;
  logic                    illegal_insn;

  logic [rv_pkg::xlen-1:0] imem [imem_depth];
  logic [rv_pkg::xlen-1:0] model_regs [32];
  logic [rv_pkg::xlen-1:0] model_pc;
  int                      error_count = 0;
  int                      prog_len = 0;

  // expected response for the word at model_pc
  logic                    exp_we, exp_halt, exp_illegal;
  logic [4:0]              exp_rd;
  logic [rv_pkg::xlen-1:0] exp_data, exp_next_pc;

  tb_clock_gen #(.period_ns(period_ns)) clock_gen (.clk(clk));

  rv_core UUT (
    .clk(clk), .rst(rst), .insn(insn), .pc(pc), .wb_en(wb_en), .wb_addr(wb_addr),
    .wb_data(wb_data), .halt(halt), .illegal_insn(illegal_insn)
  );

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      error_count++;
      $display("** Error: %s expected %h actual %h (model pc %h)",
               name, expected, actual, model_pc);
    end
  endtask

  // combinational fetch, words outside the memory decode as illegal
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr < 32'(imem_depth * 4)) begin
      return imem[addr[7:2]];
    end
    return 32'h0;
  endfunction

  // base integer result, grouped by funct3
  function automatic logic [31:0] alu_value(input logic [2:0] f3, input logic sub,
                                            input logic arith, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f3)
      3'd0: return sub ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (arith) return $unsigned($signed(a) >>> b[4:0]);
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic predict(input logic [31:0] w);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a, b, i_imm, b_imm, u_imm;
    f7    = w[31:25];
    f3    = w[14:12];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    i_imm = {{20{w[31]}}, w[31:20]};
    b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    u_imm = {w[31:12], 12'h000};
    exp_we      = 1'b0;
    exp_rd      = w[11:7];
    exp_data    = '0;
    exp_halt    = 1'b0;
    exp_illegal = 1'b0;
    exp_next_pc = model_pc + 32'd4;
    case (rv_pkg::opcode_e'(w[6:0]))
      rv_pkg::op_lui: begin
        exp_we   = 1'b1;
        exp_data = u_imm;
      end
      rv_pkg::op_auipc: begin
        exp_we   = 1'b1;
        exp_data = model_pc + u_imm;
      end
      rv_pkg::op_branch: begin
        if (f3 == 3'd0 && a == b) exp_next_pc = model_pc + b_imm;
        else if (f3 == 3'd1 && a != b) exp_next_pc = model_pc + b_imm;
        else if (f3 > 3'd1) exp_illegal = 1'b1;
      end
      rv_pkg::op_reg_imm: begin
        exp_we      = 1'b1;
        exp_data    = alu_value(f3, 1'b0, f7[5], a, i_imm);
        exp_illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                      (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      end
      rv_pkg::op_reg_reg: begin
        exp_we      = 1'b1;
        exp_data    = alu_value(f3, f7 == 7'h20, f7 == 7'h20, a, b);
        exp_illegal = f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end
      rv_pkg::op_environ: begin
        exp_halt    = (w[31:7] == 25'd0);  // ecall only
        exp_illegal = !exp_halt;
      end
      default: exp_illegal = 1'b1;
    endcase
    if (exp_illegal) exp_we = 1'b0;
  endtask

  initial begin
    int unsigned extra_cycles;
    int          reset_cycles;
    int          words;
    logic        done;
    rst  = 1'b1;
    insn = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = '0;
    $readmemh(patterns_file, imem);
    words = imem_depth;
    for (int i = imem_depth - 1; i >= 0; i--) begin
      if (imem[i] == 32'h0000_0073) words = i + 1;  // program ends at the ecall
    end
    prog_len = words;
    void'($urandom(rand_seed));
    extra_cycles = $urandom % 4;
    reset_cycles = reset_min + int'(extra_cycles);

    @(posedge clk);
    repeat (reset_cycles) begin
      @(negedge clk);
      compare_value("pc", '0, pc);
      compare_value("wb_en", 32'd0, 32'(wb_en));
      compare_value("halt", 32'd0, 32'(halt));
      compare_value("illegal_insn", 32'd0, 32'(illegal_insn));
    end
    @(posedge clk);
    rst  <= 1'b0;
    insn <= fetch_word(32'd0);

    done = 1'b0;
    while (!done) begin
      @(negedge clk);  // outputs settled for the current word
      predict(fetch_word(model_pc));
      compare_value("pc", model_pc, pc);
      compare_value("wb_en", 32'(exp_we), 32'(wb_en));
      if (exp_we) begin
        compare_value("wb_addr", 32'(exp_rd), 32'(wb_addr));
        compare_value("wb_data", exp_data, wb_data);
      end
      compare_value("halt", 32'(exp_halt), 32'(halt));
      compare_value("illegal_insn", 32'(exp_illegal), 32'(illegal_insn));
      if (exp_we && exp_rd != 5'd0) model_regs[exp_rd] = exp_data;
      model_pc = exp_next_pc;
      done     = exp_halt;
      if (!done) begin
        @(posedge clk);
        insn <= fetch_word(model_pc);
      end
    end

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // each word at most loop_bound times, with margin
  initial begin
    wait (prog_len > 0);
    #((reset_min + 4 + 4 * prog_len * loop_bound) * period_ns);
    $display("watchdog expired: halt never came within %0d cycles",
             4 * prog_len * loop_bound);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;  // half period per phase
    end
  end

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       insn,      // word at pc, same cycle
  output logic [rv_pkg::xlen-1:0]       pc,
  output logic                          wb_en,
  output logic [rv_pkg::reg_addr_w-1:0] wb_addr,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          halt,
  output logic                          illegal_insn
);

  rv_pkg::alu_op_e               alu_op;
  rv_pkg::src_a_e                src_a;
  rv_pkg::src_b_e                src_b;
  logic [rv_pkg::xlen-1:0]       imm;
  logic [rv_pkg::reg_addr_w-1:0] rd, rs1, rs2;
  logic                          rd_we;
  logic                          is_beq, is_bne;
  logic [rv_pkg::xlen-1:0]       rs1_data, rs2_data;
  logic [rv_pkg::xlen-1:0]       alu_a, alu_b;
  logic [rv_pkg::xlen-1:0]       result;

  rv_decoder u_decoder (
    .insn(insn), .rst(rst), .alu_op(alu_op), .src_a(src_a), .src_b(src_b),
    .imm(imm), .rd(rd), .rs1(rs1), .rs2(rs2), .rd_we(rd_we),
    .is_beq(is_beq), .is_bne(is_bne), .halt(halt), .illegal_insn(illegal_insn)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .we(rd_we), .rd(rd), .rs1(rs1), .rs2(rs2),
    .rd_data(result), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // operand muxes
  always_comb begin
    case (src_a)
      rv_pkg::src_a_rs1: alu_a = rs1_data;
      rv_pkg::src_a_pc:  alu_a = pc;      // auipc
      default:           alu_a = '0;
    endcase
  end

  assign alu_b = (src_b == rv_pkg::src_b_imm) ? imm : rs2_data;

  rv_alu u_alu (.alu_op(alu_op), .a(alu_a), .b(alu_b), .result(result));

  rv_pc_unit u_pc_unit (
    .clk(clk), .rst(rst), .is_beq(is_beq), .is_bne(is_bne),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc)
  );

  // commit seen one edge ahead
  assign wb_en   = rd_we;
  assign wb_addr = rd;
  assign wb_data = result;

endmodule

/* rv_pc_unit.sv */
`timescale 1ns/1ps

module rv_pc_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    is_beq,
  input  logic                    is_bne,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] imm,
  output logic [rv_pkg::xlen-1:0] pc
);

  logic                    equal;
  logic                    taken;
  logic [rv_pkg::xlen-1:0] offset;
  logic [rv_pkg::xlen-1:0] pc_next;

  assign equal = (rs1_data == rs2_data);
  assign taken = (is_beq && equal) || (is_bne && !equal);

  // b immediate is already sign extended
  assign offset  = taken ? imm : rv_pkg::pc_step;
  assign pc_next = pc + offset;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;  // keeps stepping during halt
    end
  end

endmodule

/* rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e         alu_op,
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  output logic [rv_pkg::xlen-1:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // upper bits ignored for every shift

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:
        result = a + b;
      rv_pkg::alu_sub:
        result = a - b;
      rv_pkg::alu_sll:
        result = a << shamt;
      rv_pkg::alu_slt:
        result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu:
        result = {31'b0, a < b};
      rv_pkg::alu_xor:
        result = a ^ b;
      rv_pkg::alu_srl:
        result = a >> shamt;
      rv_pkg::alu_sra:
        result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:
        result = a | b;
      rv_pkg::alu_and:
        result = a & b;
      rv_pkg::alu_pass_b:
        result = b;
      default:
        result = '0;
    endcase
  end

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::xlen-1:0]       rd_data,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [rv_pkg::num_regs];

  // x0 always reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // writes to x0 are dropped
      regs[rd] <= rd_data;
    end
  end

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  logic [rv_pkg::xlen-1:0]       insn,
  input  logic                          rst,
  output rv_pkg::alu_op_e               alu_op,
  output rv_pkg::src_a_e                src_a,
  output rv_pkg::src_b_e                src_b,
  output logic [rv_pkg::xlen-1:0]       imm,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic                          rd_we,
  output logic                          is_beq,
  output logic                          is_bne,
  output logic                          halt,
  output logic                          illegal_insn
);

  rv_pkg::opcode_e   opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [rv_pkg::xlen-1:0] imm_i, imm_b, imm_u;
  logic              we_dec, ecall, bad;

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};

  always_comb begin
    alu_op = rv_pkg::alu_add;
    src_a  = rv_pkg::src_a_rs1;
    src_b  = rv_pkg::src_b_imm;
    imm    = imm_i;
    we_dec = 1'b0;
    is_beq = 1'b0;
    is_bne = 1'b0;
    ecall  = 1'b0;
    bad    = 1'b0;

    case (opcode)
      rv_pkg::op_lui: begin
        alu_op = rv_pkg::alu_pass_b;
        src_a  = rv_pkg::src_a_zero;  // unused by pass_b
        imm    = imm_u;
        we_dec = 1'b1;
      end
      rv_pkg::op_auipc: begin
        src_a  = rv_pkg::src_a_pc;
        imm    = imm_u;
        we_dec = 1'b1;
      end
      rv_pkg::op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000:  is_beq = 1'b1;
          3'b001:  is_bne = 1'b1;
          default: bad = 1'b1;  // blt/bge family not supported
        endcase
      end
      rv_pkg::op_reg_imm: begin
        we_dec = 1'b1;
        case (funct3)
          3'b000: alu_op = rv_pkg::alu_add;
          3'b010: alu_op = rv_pkg::alu_slt;
          3'b011: alu_op = rv_pkg::alu_sltu;
          3'b100: alu_op = rv_pkg::alu_xor;
          3'b110: alu_op = rv_pkg::alu_or;
          3'b111: alu_op = rv_pkg::alu_and;
          3'b001: begin
            alu_op = rv_pkg::alu_sll;
            bad    = (funct7 != 7'b0000000);
          end
          default: begin  // srli / srai
            alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            bad    = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        src_b  = rv_pkg::src_b_rs2;
        we_dec = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b001:  alu_op = rv_pkg::alu_sll;
          3'b010:  alu_op = rv_pkg::alu_slt;
          3'b011:  alu_op = rv_pkg::alu_sltu;
          3'b100:  alu_op = rv_pkg::alu_xor;
          3'b101:  alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'b110:  alu_op = rv_pkg::alu_or;
          default: alu_op = rv_pkg::alu_and;
        endcase
        // only sub and sra take the alternate funct7
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          bad = 1'b1;
        end
      end
      rv_pkg::op_environ: begin
        ecall = (insn[31:7] == 25'd0);
        bad   = !ecall;  // ebreak, csr ops
      end
      default: bad = 1'b1;
    endcase
  end

  assign rd_we        = we_dec && !bad && !rst;
  assign halt         = ecall && !rst;
  assign illegal_insn = bad && !rst;

endmodule

/* rv_pkg.sv */
package rv_pkg;

  // datapath sizes
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  localparam logic [xlen-1:0] pc_step = 4;  // bytes per instruction

  // major opcodes, RV32I base map
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_branch  = 7'b1100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_environ = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // lui
  } alu_op_e;

  // operand a source
  typedef enum logic [1:0] {
    src_a_rs1,
    src_a_pc,
    src_a_zero
  } src_a_e;

  // operand b source
  typedef enum logic [0:0] {
    src_b_rs2,
    src_b_imm
  } src_b_e;

endpackage
